//--- filelist.f
hdl/soc_pkg.sv
hdl/addr_decoder.sv
hdl/boot_rom.sv
hdl/sram_bank.sv
hdl/resp_mux.sv
hdl/debug_ctrl.sv
hdl/soc_mem_subsystem.sv
verification/soc_mem_subsystem_sva.sv
verification/tb_clk_gen.sv
verification/tb_soc_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_mem_subsystem -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qx "sim passed" "$LOG" && [ "$run_status" -eq 0 ]; then
  echo "Simulation PASSED"
  exit 0
fi

echo "Simulation FAILED, see $LOG"
exit 1

//--- verification/tb_soc_mem_subsystem.sv
/*
 * Testbench for the memory subsystem, LFSR stimulus checked against a
 * model of the memories, the memory-side reset and the debug gate
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem_subsystem;

  import soc_pkg::*;

  localparam int unsigned POR_TIMEOUT  = 20;
  localparam int unsigned RST_TIMEOUT  = 8;
  localparam int unsigned GATE_TIMEOUT = DEBUG_DELAY_CYCLES + 20;
  localparam int unsigned NUM_RANDOM   = 3000;
  localparam int unsigned NUM_RAW      = 32;

  logic     clk;
  logic     rst_n;
  logic     ndmreset;
  logic     req_valid;
  mem_req_t req;
  logic     debug_req;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     mem_rst_n;
  logic     debug_req_gated;

  logic [31:0]           lfsr_q = 32'h8dd7_6cdf;
  logic [DATA_WIDTH-1:0] sram_model [SRAM_WORDS];
  mem_rsp_t              exp_q [$];
  logic                  pend;
  logic                  samp_rst_n;
  logic                  samp_ndm;
  int unsigned           gate_cnt;
  int unsigned           rel_edges;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_mem_subsystem i_soc_mem_subsystem (
    .clk_i       ( clk             ),
    .rst_ni      ( rst_n           ),
    .ndmreset_i  ( ndmreset        ),
    .req_valid_i ( req_valid       ),
    .req_i       ( req             ),
    .debug_req_i ( debug_req       ),
    .rsp_valid_o ( rsp_valid       ),
    .rsp_o       ( rsp             ),
    .rst_no      ( mem_rst_n       ),
    .debug_req_o ( debug_req_gated )
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, want));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  // Expected answer of one accepted request, updates the SRAM model
  function automatic mem_rsp_t model_access(input mem_req_t r);
    mem_rsp_t    m;
    int unsigned idx;
    m = '{err: 1'b1, rdata: '0};
    if (r.addr >= ROM_BASE && r.addr < ROM_BASE + ROM_LENGTH) begin
      idx     = int'((r.addr - ROM_BASE) >> BYTE_OFFSET);
      m.err   = 1'b0;
      m.rdata = (idx < ROM_WORDS) ? BOOT_IMAGE[idx] : '0;
    end else if (r.addr >= SRAM_BASE && r.addr < SRAM_BASE + SRAM_LENGTH) begin
      idx   = int'((r.addr - SRAM_BASE) >> BYTE_OFFSET);
      m.err = 1'b0;
      if (r.we) begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (r.be[b]) begin
            sram_model[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
          end
        end
      end else begin
        m.rdata = sram_model[idx];
      end
    end else if (r.addr >= STUB_BASE && r.addr < STUB_BASE + STUB_LENGTH) begin
      m.rdata = STUB_RDATA;
    end
    return m;
  endfunction

  function automatic mem_req_t random_req(input logic sram_only);
    mem_req_t   r;
    logic [2:0] region;
    region  = 3'(rand_bits(3));
    r.we    = 1'(rand_bits(1));
    r.be    = BE_WIDTH'(rand_bits(BE_WIDTH));
    r.wdata = rand_bits(DATA_WIDTH);
    if (sram_only) begin
      region[2] = 1'b1;
    end
    case (region)
      3'd0, 3'd3: r.addr = ROM_BASE + 32'(rand_bits(7));
      3'd1:       r.addr = STUB_BASE + 32'(rand_bits(12));
      3'd2:       r.addr = 32'(rand_bits(32));
      3'd4, 3'd5: r.addr = SRAM_BASE + 32'(rand_bits(13));
      // Few words, many hits on the same word
      default:    r.addr = SRAM_BASE + 32'(rand_bits(6));
    endcase
    return r;
  endfunction

  task automatic drive_random(input logic sram_only);
    req_valid = (rand_bits(2) != 0);
    req       = random_req(sram_only);
  endtask

  task automatic check_outputs();
    mem_rsp_t m;
    logic     exp_dbg;
    exp_dbg = (gate_cnt == 0) ? debug_req : 1'b0;
    assert (i_soc_mem_subsystem.i_soc_mem_subsystem_sva.fail_count == 0)
      else abort_run("a bound port assertion failed");
    assert (mem_rst_n == (rel_edges >= 2))
      else value_error("rst_no", mem_rst_n, rel_edges >= 2);
    assert (debug_req_gated == exp_dbg)
      else value_error("debug_req_o", debug_req_gated, exp_dbg);
    assert (rsp_valid == pend) else value_error("rsp_valid_o", rsp_valid, pend);
    if (pend) begin
      m = exp_q.pop_front();
      assert (rsp.err == m.err) else value_error("rsp_o.err", rsp.err, m.err);
      assert (rsp.rdata == m.rdata) else value_error("rsp_o.rdata", rsp.rdata, m.rdata);
    end
  endtask

  // Model one clock edge, then check what the DUT shows after it
  task automatic step();
    @(negedge clk);
    samp_rst_n = rst_n;
    samp_ndm   = ndmreset;
    if (!samp_rst_n || samp_ndm) begin
      rel_edges = 0;
    end
    if (!samp_rst_n) begin
      gate_cnt = DEBUG_DELAY_CYCLES;
    end
    pend = req_valid && (rel_edges >= 2);
    if (pend) begin
      exp_q.push_back(model_access(req));
    end
    @(posedge clk);
    #1;
    if (samp_rst_n && !samp_ndm && rel_edges < 2) begin
      rel_edges++;
    end
    if (samp_rst_n) begin
      if (gate_cnt > 0) begin
        gate_cnt--;
      end
    end
    check_outputs();
  endtask

  initial begin
    int unsigned cnt;
    mem_req_t    r;
    ndmreset   = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    debug_req  = 1'b1;
    gate_cnt   = DEBUG_DELAY_CYCLES;
    rel_edges  = 0;
    pend       = 1'b0;
    samp_rst_n = 1'b0;
    samp_ndm   = 1'b0;
    for (int i = 0; i < SRAM_WORDS; i++) begin
      sram_model[i] = '0;
    end

    // ----------------------------------------------------------
    // Power-on reset and debug gate
    // ----------------------------------------------------------
    cnt = 0;
    while (samp_rst_n !== 1'b1) begin
      step();
      cnt++;
      if (cnt > POR_TIMEOUT) begin
        abort_run("power-on reset was never released");
      end
    end

    // SRAM traffic while the gate is still closed
    cnt = 0;
    while (debug_req_gated !== 1'b1) begin
      drive_random(1'b1);
      step();
      cnt++;
      if (cnt > GATE_TIMEOUT) begin
        abort_run("debug request gate never opened");
      end
    end

    // ----------------------------------------------------------
    // Mixed traffic over all regions
    // ----------------------------------------------------------
    for (int i = 0; i < NUM_RANDOM; i++) begin
      drive_random(1'b0);
      debug_req = 1'(rand_bits(1));
      step();
    end

    // Read right after a write to the same word
    for (int i = 0; i < NUM_RAW; i++) begin
      r         = random_req(1'b1);
      r.we      = 1'b1;
      req_valid = 1'b1;
      req       = r;
      step();
      r.we = 1'b0;
      req  = r;
      step();
    end

    // ----------------------------------------------------------
    // Non-debug reset
    // ----------------------------------------------------------
    debug_req = 1'b1;
    req_valid = 1'b0;
    ndmreset  = 1'b1;
    #1;
    assert (!mem_rst_n) else abort_run("rst_no did not fall with ndmreset_i");
    for (int i = 0; i < 4; i++) begin
      drive_random(1'b1);
      req_valid = 1'b1;
      step();
    end
    ndmreset = 1'b0;
    cnt = 0;
    while (!mem_rst_n) begin
      drive_random(1'b1);
      step();
      cnt++;
      if (cnt > RST_TIMEOUT) begin
        abort_run("rst_no did not rise after ndmreset_i was released");
      end
    end

    // Whole SRAM read back after the reset
    for (int i = 0; i < SRAM_WORDS; i++) begin
      req_valid = 1'b1;
      req       = '0;
      req.addr  = SRAM_BASE + ADDR_WIDTH'(i * BE_WIDTH);
      step();
    end
    req_valid = 1'b0;
    step();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HALF_PERIOD  = 5;
  localparam int unsigned RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release a little after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/soc_mem_subsystem_sva.sv
/*
 * Concurrent checks on the memory subsystem ports, bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

module soc_mem_subsystem_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic rsp_valid_o,
  input logic rst_no,
  input logic debug_req_i,
  input logic debug_req_o
);

  // Failed assertions so far, polled by the testbench
  int unsigned fail_count = 0;

  // Response only for a request accepted one edge earlier
  rsp_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> $past(req_valid_i && rst_no)
  ) else begin
    fail_count++;
    $error("response without an accepted request");
  end

  rsp_quiet_in_reset: assert property (
    @(posedge clk_i) !rst_no |-> !rsp_valid_o
  ) else begin
    fail_count++;
    $error("response while the memory side is in reset");
  end

  debug_follows_input: assert property (
    @(posedge clk_i) debug_req_o |-> debug_req_i
  ) else begin
    fail_count++;
    $error("debug request out without a debug request in");
  end

endmodule

bind soc_mem_subsystem soc_mem_subsystem_sva i_soc_mem_subsystem_sva (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_valid_i ( req_valid_i ),
  .rsp_valid_o ( rsp_valid_o ),
  .rst_no      ( rst_no      ),
  .debug_req_i ( debug_req_i ),
  .debug_req_o ( debug_req_o )
);

`default_nettype wire

//--- hdl/soc_mem_subsystem.sv
/*
 * Memory subsystem top level with decoder, boot ROM, main memory,
 * response mux and reset/debug control
 */
`timescale 1ns/1ps
`default_nettype none

module soc_mem_subsystem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ndmreset_i,
  input  logic              req_valid_i,
  input  soc_pkg::mem_req_t req_i,
  input  logic              debug_req_i,
  output logic              rsp_valid_o,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic              rst_no,
  output logic              debug_req_o
);

  import soc_pkg::*;

  logic                  mem_rst_n;
  slave_e                slave;
  logic                  rom_en;
  logic                  sram_en;
  logic [DATA_WIDTH-1:0] rom_rdata;
  logic [DATA_WIDTH-1:0] sram_rdata;

  // ----------------------------------------------------------
  // Reset and debug
  // ----------------------------------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .mem_rst_no  ( mem_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  assign rst_no = mem_rst_n;

  // ----------------------------------------------------------
  // Decode and memories
  // ----------------------------------------------------------
  addr_decoder i_addr_decoder (
    .req_i   ( req_i ),
    .slave_o ( slave )
  );

  assign rom_en  = req_valid_i & (slave == SLV_ROM);
  assign sram_en = req_valid_i & (slave == SLV_SRAM);

  boot_rom i_boot_rom (
    .clk_i   ( clk_i      ),
    .rst_ni  ( mem_rst_n  ),
    .en_i    ( rom_en     ),
    .addr_i  ( req_i.addr ),
    .rdata_o ( rom_rdata  )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .rst_ni  ( mem_rst_n  ),
    .en_i    ( sram_en    ),
    .req_i   ( req_i      ),
    .rdata_o ( sram_rdata )
  );

  resp_mux i_resp_mux (
    .clk_i        ( clk_i       ),
    .rst_ni       ( mem_rst_n   ),
    .req_valid_i  ( req_valid_i ),
    .slave_i      ( slave       ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_o        ( rsp_o       )
  );

endmodule

`default_nettype wire

//--- hdl/debug_ctrl.sv
/*
 * Memory-side reset generator and post-reset debug request gate
 */
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  output logic mem_rst_no,
  output logic debug_req_o
);

  import soc_pkg::*;

  logic                       comb_rst_n;
  logic [1:0]                 sync_q;
  logic [DEBUG_CNT_WIDTH-1:0] del_cnt_q;

  // ----------------------------------------------------------
  // Reset synchronizer
  // ----------------------------------------------------------
  // Asserts at once, releases on the second edge
  assign comb_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign mem_rst_no = sync_q[1];

  // ----------------------------------------------------------
  // Debug request gate
  // ----------------------------------------------------------
  // Gives boot code time to run before the first debug request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= DEBUG_CNT_WIDTH'(DEBUG_DELAY_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (del_cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

//--- hdl/resp_mux.sv
/*
 * Response mux, tracks the slave in flight and builds the response
 * including the stub and decode-error answers
 */
`timescale 1ns/1ps
`default_nettype none

module resp_mux (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_valid_i,
  input  soc_pkg::slave_e                  slave_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0]   rom_rdata_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0]   sram_rdata_i,
  output logic                             rsp_valid_o,
  output soc_pkg::mem_rsp_t                rsp_o
);

  import soc_pkg::*;

  logic   valid_q;
  slave_e slave_q;

  // One request in flight per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      slave_q <= SLV_NONE;
    end else begin
      valid_q <= req_valid_i;
      slave_q <= slave_i;
    end
  end

  always_comb begin
    unique case (slave_q)
      SLV_ROM: begin
        rsp_o = '{err: 1'b0, rdata: rom_rdata_i};
      end
      SLV_SRAM: begin
        rsp_o = '{err: 1'b0, rdata: sram_rdata_i};
      end
      SLV_STUB: begin
        rsp_o = '{err: 1'b1, rdata: STUB_RDATA};
      end
      default: begin
        // Decode error
        rsp_o = '{err: 1'b1, rdata: '0};
      end
    endcase
  end

  assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hdl/sram_bank.sv
/*
 * Main memory, single port with byte enables and a registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  soc_pkg::mem_req_t                req_i,
  output logic [soc_pkg::DATA_WIDTH-1:0]   rdata_o
);

  import soc_pkg::*;

  logic [SRAM_IDX_WIDTH-1:0] word_idx;
  logic [DATA_WIDTH-1:0]     rdata_q;

  // Cleared at power-up only, contents live through a memory-side reset
  logic [DATA_WIDTH-1:0] mem_q [SRAM_WORDS] = '{default: '0};

  assign word_idx = req_i.addr[SRAM_IDX_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (en_i) begin
      if (req_i.we) begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
        // Writes answer with zero data
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/boot_rom.sv
/*
 * Boot ROM with the fixed image and a registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0]   addr_i,
  output logic [soc_pkg::DATA_WIDTH-1:0]   rdata_o
);

  import soc_pkg::*;

  logic [ROM_IDX_WIDTH-1:0] word_idx;
  logic [DATA_WIDTH-1:0]    rdata_q;

  assign word_idx = addr_i[ROM_IDX_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (en_i) begin
      // Window is larger than the image, the rest reads as zero
      if (word_idx < ROM_IDX_WIDTH'(ROM_WORDS)) begin
        rdata_q <= BOOT_IMAGE[word_idx[ROM_SEL_WIDTH-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/addr_decoder.sv
/*
 * Address decoder, maps a request onto a slave by the rule table
 */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::slave_e   slave_o
);

  import soc_pkg::*;

  logic [ADDR_WIDTH-1:0] offset;

  // Walk backwards so the lowest matching rule is the last one assigned
  always_comb begin
    slave_o = SLV_NONE;
    offset  = '0;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      offset = req_i.addr - ADDR_MAP[i].base;
      // Unsigned offset covers both bounds at once
      if (offset < ADDR_MAP[i].length) begin
        slave_o = ADDR_MAP[i].slave;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_pkg.sv
/*
 * Shared widths, address map and boot image of the memory subsystem,
 * slave enumeration and the request/response structs
 */
`default_nettype none

package soc_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;
  localparam int unsigned BYTE_OFFSET = $clog2(BE_WIDTH);

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam logic [ADDR_WIDTH-1:0] ROM_BASE    = 32'h0001_0000;
  localparam logic [ADDR_WIDTH-1:0] ROM_LENGTH  = 32'h0000_1000;
  localparam logic [ADDR_WIDTH-1:0] STUB_BASE   = 32'h4000_0000;
  localparam logic [ADDR_WIDTH-1:0] STUB_LENGTH = 32'h0000_1000;
  localparam logic [ADDR_WIDTH-1:0] SRAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_WIDTH-1:0] SRAM_LENGTH = 32'h0000_2000;

  localparam int unsigned SRAM_WORDS     = SRAM_LENGTH / BE_WIDTH;
  localparam int unsigned SRAM_IDX_WIDTH = $clog2(SRAM_WORDS);
  localparam int unsigned ROM_WORDS      = 8;
  localparam int unsigned ROM_SEL_WIDTH  = $clog2(ROM_WORDS);
  // Word index over the whole ROM window, wider than the image
  localparam int unsigned ROM_IDX_WIDTH  = $clog2(ROM_LENGTH / BE_WIDTH);

  localparam int unsigned DEBUG_DELAY_CYCLES = 500;
  localparam int unsigned DEBUG_CNT_WIDTH    = $clog2(DEBUG_DELAY_CYCLES + 1);

  localparam logic [DATA_WIDTH-1:0] STUB_RDATA = 64'h0000_0000_dead_beef;

  typedef enum logic [1:0] {
    SLV_ROM  = 2'd0,
    SLV_SRAM = 2'd1,
    SLV_STUB = 2'd2,
    SLV_NONE = 2'd3
  } slave_e;

  typedef struct packed {
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  err;
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    slave_e                slave;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] length;
  } addr_rule_t;

  localparam int unsigned NUM_RULES = 3;

  // First matching rule wins
  localparam addr_rule_t ADDR_MAP [NUM_RULES] = '{
    '{slave: SLV_ROM,  base: ROM_BASE,  length: ROM_LENGTH},
    '{slave: SLV_SRAM, base: SRAM_BASE, length: SRAM_LENGTH},
    '{slave: SLV_STUB, base: STUB_BASE, length: STUB_LENGTH}
  };

  // Boot code, jumps to the start of main memory
  localparam logic [DATA_WIDTH-1:0] BOOT_IMAGE [ROM_WORDS] = '{
    64'h0010_0293_f140_2573,
    64'h01f2_9293_0000_0597,
    64'h0002_8067_0405_8593,
    64'h1050_0073_0000_0013,
    64'h0000_0000_ffdf_f06f,
    64'h8000_0000_0000_0000,
    64'h0000_0001_0000_1000,
    64'hc0ff_ee00_5eed_0001
  };

endpackage

`default_nettype wire
